/* design/peripheral_bb_macros.svh */
`ifndef PERIPHERAL_BB_MACROS_SVH
`define PERIPHERAL_BB_MACROS_SVH

////////////////////////////////////////
// Memory geometry
////////////////////////////////////////

// RAM size in bytes
// Any power of two of 64 or more
`define BB_DEPTH 1024

// Byte address width derived from the depth
`define BB_AW ($clog2(`BB_DEPTH))

////////////////////////////////////////
// Burst wrap sizes
////////////////////////////////////////

// Beats per wrap block, one word per beat
`define BB_WRAP_4 4
`define BB_WRAP_8 8
// Largest block still needs 4 index bits
`define BB_WRAP_16 16

`endif

/* design/peripheral_bb_pkg.sv */
`include "peripheral_bb_macros.svh"

package peripheral_bb_pkg;

  ////////////////////////////////////////
  // Bus vectors
  ////////////////////////////////////////

  // Byte address as seen on the bus
  typedef logic [`BB_AW-1:0] bb_adr_t;

  // Word index into the RAM
  // Two byte offset bits dropped
  typedef logic [`BB_AW-3:0] bb_word_adr_t;

  // Fixed 32-bit data path
  typedef logic [31:0] bb_dat_t;

  // One select bit per byte lane
  typedef logic [3:0] bb_sel_t;

  ////////////////////////////////////////
  // Cycle and burst encodings
  ////////////////////////////////////////

  // Cycle type identifier
  // Codes 3 to 6 are reserved and get an error
  typedef enum logic [2:0] {
    CTI_CLASSIC      = 3'b000,
    CTI_CONST_BURST  = 3'b001,
    CTI_INC_BURST    = 3'b010,
    CTI_END_OF_BURST = 3'b111
  } bb_cti_e;

  // Burst type extension, only meaningful for incrementing bursts
  typedef enum logic [1:0] {
    BTE_LINEAR  = 2'd0,
    BTE_WRAP_4  = 2'd1,
    BTE_WRAP_8  = 2'd2,
    BTE_WRAP_16 = 2'd3
  } bb_bte_e;

  ////////////////////////////////////////
  // Request and response
  ////////////////////////////////////////

  // Master to slave, held stable until ack or err
  typedef struct packed {
    bb_adr_t adr;
    bb_dat_t dat;
    bb_sel_t sel;
    logic    we;
    bb_bte_e bte;
    bb_cti_e cti;
    logic    cyc;
    logic    stb;
  } bb_req_t;

  // Slave to master
  typedef struct packed {
    logic    ack;
    logic    err;
    bb_dat_t dat;
  } bb_rsp_t;

  // Controller states
  typedef enum logic [1:0] {
    IDLE,
    BEAT,
    BURST
  } ctrl_state_e;

endpackage

/* design/peripheral_ram_generic_bb.sv */
module peripheral_ram_generic_bb #(
  // Number of 32-bit words
  parameter int DEPTH = 256
) (
  input  logic                            bb_clk_i,

  // Write port
  input  peripheral_bb_pkg::bb_sel_t      we_i,
  input  peripheral_bb_pkg::bb_word_adr_t waddr_i,
  input  peripheral_bb_pkg::bb_dat_t      din_i,

  // Read port
  input  peripheral_bb_pkg::bb_word_adr_t raddr_i,
  output peripheral_bb_pkg::bb_dat_t      dout_o
);

  import peripheral_bb_pkg::*;

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // One enable per byte lane
  localparam int LANES = $bits(bb_sel_t);
  localparam int LANE_W = $bits(bb_dat_t) / LANES;

  // Contents undefined until written
  bb_dat_t mem [DEPTH];

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  // Each lane lands independently
  always_ff @(posedge bb_clk_i) begin
    for (int i = 0; i < LANES; i++) begin
      if (we_i[i]) begin
        mem[waddr_i][i*LANE_W +: LANE_W] <= din_i[i*LANE_W +: LANE_W];
      end
    end
  end

  ////////////////////////////////////////
  // Read port
  ////////////////////////////////////////

  // Registered read, one cycle latency
  // Same cycle write to raddr returns the old word
  always_ff @(posedge bb_clk_i) begin
    dout_o <= mem[raddr_i];
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Index width can exceed the array when DEPTH is not a power of two
  a_waddr_range : assert property (
    @(posedge bb_clk_i)
    (|we_i) |-> (int'(waddr_i) < DEPTH)
  );

endmodule

/* design/peripheral_bb_burst_ctrl.sv */
`include "peripheral_bb_macros.svh"

module peripheral_bb_burst_ctrl (
  input  logic                            bb_clk_i,
  input  logic                            bb_rst_i,

  input  peripheral_bb_pkg::bb_req_t      req_i,

  output logic                            ack_o,
  output logic                            err_o,

  output peripheral_bb_pkg::bb_word_adr_t ram_waddr_o,
  output peripheral_bb_pkg::bb_sel_t      ram_we_o,
  output peripheral_bb_pkg::bb_dat_t      ram_wdata_o,
  output peripheral_bb_pkg::bb_word_adr_t ram_raddr_o
);

  import peripheral_bb_pkg::*;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Anything outside the four defined codes is reserved
  function automatic logic cti_is_reserved(input bb_cti_e cti);
    logic res;
    case (cti)
      CTI_CLASSIC,
      CTI_CONST_BURST,
      CTI_INC_BURST,
      CTI_END_OF_BURST: res = 1'b0;
      default:          res = 1'b1;
    endcase
    return res;
  endfunction

  // Word index of the beat that follows cur
  function automatic bb_word_adr_t next_word(
    input bb_word_adr_t cur,
    input bb_cti_e      cti,
    input bb_bte_e      bte
  );
    bb_word_adr_t mask;
    bb_word_adr_t nxt;
    // Mask selects the index bits allowed to count
    case (bte)
      BTE_WRAP_4:  mask = bb_word_adr_t'(`BB_WRAP_4 - 1);
      BTE_WRAP_8:  mask = bb_word_adr_t'(`BB_WRAP_8 - 1);
      BTE_WRAP_16: mask = bb_word_adr_t'(`BB_WRAP_16 - 1);
      default:     mask = '1;
    endcase
    // Constant bursts and final beats hold the address
    nxt = cur;
    if (cti == CTI_INC_BURST) begin
      // Upper bits frozen, lower bits roll over inside the block
      nxt = (cur & ~mask) | ((cur + 1'b1) & mask);
    end
    return nxt;
  endfunction

  ////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////

  ctrl_state_e  state_q;
  ctrl_state_e  state_d;
  logic         valid;
  logic         reserved;
  logic         is_last;
  logic         new_cycle;
  logic         ack_d;
  logic         wr_beat;
  bb_word_adr_t req_word;
  bb_word_adr_t adr_q;
  bb_word_adr_t adr_d;
  bb_word_adr_t next_adr;

  // Beat requested
  assign valid    = req_i.cyc & req_i.stb;
  assign reserved = valid & cti_is_reserved(req_i.cti);

  // Classic, end of burst and error beats all close the cycle
  assign is_last  = (req_i.cti == CTI_CLASSIC) |
                    (req_i.cti == CTI_END_OF_BURST) |
                    cti_is_reserved(req_i.cti);

  assign req_word = req_i.adr[`BB_AW-1:2];

  ////////////////////////////////////////
  // Cycle tracking FSM
  ////////////////////////////////////////

  // IDLE    no beat seen last cycle
  // BEAT    last cycle held a closing beat
  // BURST   burst running, address comes from the predictor
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE, BEAT: begin
        if (valid) begin
          state_d = is_last ? BEAT : BURST;
        end else begin
          state_d = IDLE;
        end
      end
      BURST: begin
        // Master dropping stb mid burst abandons it
        if (!valid) begin
          state_d = IDLE;
        end else if (is_last) begin
          state_d = BEAT;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // Fresh request or first beat after a closing one
  assign new_cycle = (state_q != BURST);

  ////////////////////////////////////////
  // Address prediction
  ////////////////////////////////////////

  assign next_adr = next_word(adr_q, req_i.cti, req_i.bte);
  assign adr_d    = new_cycle ? req_word : next_adr;

  // Holds the index of the beat being acknowledged
  always_ff @(posedge bb_clk_i) begin
    adr_q <= adr_d;
  end

  // Read one beat ahead so data lines up with ack
  assign ram_raddr_o = adr_d;

  ////////////////////////////////////////
  // Ack, err and write strobe
  ////////////////////////////////////////

  // Bursts keep ack high, a closing beat drops it for a cycle
  assign ack_d = valid & ~reserved & (~is_last | ~ack_o);

  always_ff @(posedge bb_clk_i) begin
    if (bb_rst_i) begin
      state_q <= IDLE;
      ack_o   <= 1'b0;
      err_o   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_o   <= ack_d;
      // single cycle error pulse per reserved beat
      err_o   <= reserved & ~err_o;
    end
  end

  // Commit only on an acknowledged write
  assign wr_beat     = valid & req_i.we & ack_o & ~reserved;
  assign ram_we_o    = wr_beat ? req_i.sel : '0;
  assign ram_waddr_o = adr_q;
  assign ram_wdata_o = req_i.dat;

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // A beat ends with exactly one of ack or err
  a_ack_err_excl : assert property (
    @(posedge bb_clk_i) disable iff (bb_rst_i)
    !(ack_o && err_o)
  );

  // Strobe only under ack and at the word the master addresses
  a_we_on_ack : assert property (
    @(posedge bb_clk_i) disable iff (bb_rst_i)
    (|ram_we_o) |-> (ack_o && (ram_waddr_o == req_word))
  );

endmodule

/* design/peripheral_spram_bb.sv */
`include "peripheral_bb_macros.svh"

module peripheral_spram_bb (
  input  logic                       bb_clk_i,
  input  logic                       bb_rst_i,

  // Bus side
  input  peripheral_bb_pkg::bb_req_t bb_req_i,
  output peripheral_bb_pkg::bb_rsp_t bb_rsp_o
);

  import peripheral_bb_pkg::*;

  ////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////

  // Controller to RAM
  bb_word_adr_t ram_waddr;
  bb_word_adr_t ram_raddr;
  bb_sel_t      ram_we;
  bb_dat_t      ram_wdata;

  // RAM and controller back to the bus
  bb_dat_t      ram_rdata;
  logic         ack;
  logic         err;

  ////////////////////////////////////////
  // Cycle controller
  ////////////////////////////////////////

  peripheral_bb_burst_ctrl u_ctrl (
    .bb_clk_i    (bb_clk_i),
    .bb_rst_i    (bb_rst_i),
    .req_i       (bb_req_i),
    .ack_o       (ack),
    .err_o       (err),
    .ram_waddr_o (ram_waddr),
    .ram_we_o    (ram_we),
    .ram_wdata_o (ram_wdata),
    .ram_raddr_o (ram_raddr)
  );

  ////////////////////////////////////////
  // Byte lane RAM
  ////////////////////////////////////////

  // Depth in words
  peripheral_ram_generic_bb #(
    .DEPTH (`BB_DEPTH / 4)
  ) u_ram (
    .bb_clk_i (bb_clk_i),
    .we_i     (ram_we),
    .waddr_i  (ram_waddr),
    .din_i    (ram_wdata),
    .raddr_i  (ram_raddr),
    .dout_o   (ram_rdata)
  );

  // Read data goes straight out, valid whenever ack is high
  assign bb_rsp_o = '{ack: ack, err: err, dat: ram_rdata};

endmodule

/* bench/peripheral_spram_tb_tasks.svh */
////////////////////////////////////////
// Compare tasks
////////////////////////////////////////

// Data word from the bus or the model
task automatic check_dat(input string name, input bb_dat_t exp, input bb_dat_t act);
  if (act !== exp) begin
    dat_errs++;
    $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
  end
endtask

// Byte address, compared with low bits included
task automatic check_adr(input string name, input bb_adr_t exp, input bb_adr_t act);
  if (act !== exp) begin
    adr_errs++;
    $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
  end
endtask

// Single response bit
task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    flag_errs++;
    $display("[ERROR] %0t ns %s expected %b actual %b", $time, name, exp, act);
  end
endtask

////////////////////////////////////////
// Guarded waits
////////////////////////////////////////

// Sample on falling edges until the slave answers the beat
task automatic wait_resp(output logic seen);
  int n;
  seen = 1'b0;
  n = 0;
  while (!seen && n < TIMEOUT) begin
    @(negedge bb_clk);
    n++;
    seen = (bb_rsp.ack === 1'b1) || (bb_rsp.err === 1'b1);
  end
  if (!seen) begin
    timeouts++;
    $display("No ack or err within %0d cycles at %0t ns, stopping", TIMEOUT, $time);
  end
endtask

// Bus quiet again after the master drops stb
task automatic wait_idle(output logic quiet);
  int n;
  quiet = 1'b0;
  n = 0;
  while (!quiet && n < TIMEOUT) begin
    @(negedge bb_clk);
    n++;
    quiet = (bb_rsp.ack === 1'b0) && (bb_rsp.err === 1'b0);
  end
  if (!quiet) begin
    timeouts++;
    $display("Ack or err still high %0d cycles after the cycle ended at %0t ns", TIMEOUT, $time);
  end
endtask

/* bench/peripheral_spram_tb.sv */
`include "peripheral_bb_macros.svh"

module peripheral_spram_tb;
  timeunit 1ns;
  timeprecision 1ns;

  import peripheral_bb_pkg::*;

  localparam int WORDS     = `BB_DEPTH / 4;
  localparam int TIMEOUT   = 20;
  localparam int DRIVE_DLY = 5;
  localparam int N_RAND    = 24;

  // One table row is one bus transaction
  typedef struct packed {
    logic    we;
    bb_cti_e cti;
    bb_bte_e bte;
    bb_adr_t adr;
    int      beats;
    bb_sel_t sel;
  } stim_t;

  logic    bb_clk;
  logic    bb_rst;
  bb_req_t bb_req;
  bb_rsp_t bb_rsp;

  stim_t   stim_q[$];
  bb_dat_t model [WORDS];
  integer  seed = 32'h96ca_7cd2;
  int      dat_errs = 0;
  int      adr_errs = 0;
  int      flag_errs = 0;
  int      timeouts = 0;

  `include "peripheral_spram_tb_tasks.svh"

  peripheral_spram_bb u_peripheral_spram_bb (
    .bb_clk_i (bb_clk),
    .bb_rst_i (bb_rst),
    .bb_req_i (bb_req),
    .bb_rsp_o (bb_rsp)
  );

  // 100 ns clock
  initial begin
    bb_clk = 1'b0;
    forever #50 bb_clk = ~bb_clk;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Codes 3 to 6 carry no defined cycle type
  function automatic logic is_reserved_code(input bb_cti_e c);
    logic [2:0] code;
    code = c;
    return code inside {[3'd3:3'd6]};
  endfunction

  // Beat address after adr, wrapping inside an aligned block of span words
  function automatic bb_adr_t next_beat_adr(input bb_adr_t adr, input bb_cti_e cti,
                                            input bb_bte_e bte);
    int word;
    int span;
    int base;
    word = int'(adr) / 4;
    case (bte)
      BTE_WRAP_4:  span = 4;
      BTE_WRAP_8:  span = 8;
      BTE_WRAP_16: span = 16;
      default:     span = WORDS;
    endcase
    base = word - (word % span);
    if (cti != CTI_CONST_BURST) begin
      word = base + ((word - base + 1) % span);
    end
    return bb_adr_t'(word * 4);
  endfunction

  // Byte lanes land one at a time
  task automatic merge_write(input int widx, input bb_dat_t d, input bb_sel_t sel);
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) begin
        model[widx][8*i +: 8] = d[8*i +: 8];
      end
    end
  endtask

  ////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////

  function automatic stim_t stim_row(input logic we, input bb_cti_e cti, input bb_bte_e bte,
                                     input int adr, input int beats, input bb_sel_t sel);
    stim_t s;
    s.we    = we;
    s.cti   = cti;
    s.bte   = bte;
    s.adr   = bb_adr_t'(adr);
    s.beats = beats;
    s.sel   = sel;
    return s;
  endfunction

  task automatic build_table();
    // Fill every word first
    stim_q.push_back(stim_row(1, CTI_INC_BURST, BTE_LINEAR, 'h000, WORDS, 4'hf));
    // Classic partial write then read back
    stim_q.push_back(stim_row(1, CTI_CLASSIC, BTE_LINEAR, 'h040, 1, 4'b0101));
    stim_q.push_back(stim_row(0, CTI_CLASSIC, BTE_LINEAR, 'h040, 1, 4'hf));
    // Linear bursts, 6 beats
    stim_q.push_back(stim_row(1, CTI_INC_BURST, BTE_LINEAR, 'h084, 6, 4'hf));
    stim_q.push_back(stim_row(0, CTI_INC_BURST, BTE_LINEAR, 'h084, 6, 4'hf));
    // Wrap 4 from the middle of block 0x100, then both neighbours
    stim_q.push_back(stim_row(1, CTI_INC_BURST, BTE_WRAP_4, 'h108, 4, 4'hf));
    stim_q.push_back(stim_row(0, CTI_INC_BURST, BTE_WRAP_4, 'h108, 4, 4'hf));
    stim_q.push_back(stim_row(0, CTI_CLASSIC, BTE_LINEAR, 'h0fc, 1, 4'hf));
    stim_q.push_back(stim_row(0, CTI_CLASSIC, BTE_LINEAR, 'h110, 1, 4'hf));
    // Wrap 8 in block 0x200
    stim_q.push_back(stim_row(1, CTI_INC_BURST, BTE_WRAP_8, 'h214, 8, 4'b1011));
    stim_q.push_back(stim_row(0, CTI_INC_BURST, BTE_WRAP_8, 'h214, 8, 4'hf));
    stim_q.push_back(stim_row(0, CTI_CLASSIC, BTE_LINEAR, 'h1fc, 1, 4'hf));
    stim_q.push_back(stim_row(0, CTI_CLASSIC, BTE_LINEAR, 'h220, 1, 4'hf));
    // Wrap 16 in block 0x300
    stim_q.push_back(stim_row(1, CTI_INC_BURST, BTE_WRAP_16, 'h328, 16, 4'hf));
    stim_q.push_back(stim_row(0, CTI_INC_BURST, BTE_WRAP_16, 'h328, 16, 4'hf));
    stim_q.push_back(stim_row(0, CTI_CLASSIC, BTE_LINEAR, 'h2fc, 1, 4'hf));
    stim_q.push_back(stim_row(0, CTI_CLASSIC, BTE_LINEAR, 'h340, 1, 4'hf));
    // Constant address burst, last beat wins in its lanes
    stim_q.push_back(stim_row(1, CTI_CONST_BURST, BTE_LINEAR, 'h3a0, 4, 4'b0110));
    stim_q.push_back(stim_row(0, CTI_CLASSIC, BTE_LINEAR, 'h3a0, 1, 4'hf));
    // Reserved codes answered with err, word untouched
    stim_q.push_back(stim_row(1, bb_cti_e'(3'd5), BTE_LINEAR, 'h3a0, 1, 4'hf));
    stim_q.push_back(stim_row(1, bb_cti_e'(3'd3), BTE_WRAP_4, 'h3a0, 1, 4'hf));
    stim_q.push_back(stim_row(0, CTI_CLASSIC, BTE_LINEAR, 'h3a0, 1, 4'hf));
  endtask

  ////////////////////////////////////////
  // Bus driver
  ////////////////////////////////////////

  task automatic present_beat(input bb_adr_t adr, input bb_dat_t dat, input bb_sel_t sel,
                              input logic we, input bb_cti_e cti, input bb_bte_e bte);
    @(posedge bb_clk);
    #DRIVE_DLY;
    bb_req.adr = adr;
    bb_req.dat = dat;
    bb_req.sel = sel;
    bb_req.we  = we;
    bb_req.bte = bte;
    bb_req.cti = cti;
    bb_req.cyc = 1'b1;
    bb_req.stb = 1'b1;
  endtask

  // Answer of one beat, sampled mid cycle where it is stable
  task automatic take_resp(input bb_adr_t adr, input logic we, input bb_sel_t sel,
                           input logic want_err, input logic ack_now, output logic ok);
    int widx;
    widx = int'(adr) / 4;
    @(negedge bb_clk);
    // Registered ack is late on a first beat, already high inside a burst
    check_flag("bb_rsp_o.ack", ack_now, bb_rsp.ack);
    check_flag("bb_rsp_o.err", 1'b0, bb_rsp.err);
    ok = (bb_rsp.ack === 1'b1);
    if (!ok) begin
      wait_resp(ok);
    end
    if (ok) begin
      check_flag("bb_rsp_o.ack", !want_err, bb_rsp.ack);
      check_flag("bb_rsp_o.err", want_err, bb_rsp.err);
      if (!want_err && we) begin
        check_adr("ram write address", adr,
                  bb_adr_t'({u_peripheral_spram_bb.ram_waddr, 2'b00}));
        merge_write(widx, bb_req.dat, sel);
      end else if (!want_err) begin
        check_dat("bb_rsp_o.dat", model[widx], bb_rsp.dat);
      end
    end
  endtask

  task automatic end_cycle(inout logic ok);
    logic quiet;
    @(posedge bb_clk);
    #DRIVE_DLY;
    bb_req.cyc = 1'b0;
    bb_req.stb = 1'b0;
    wait_idle(quiet);
    ok = ok && quiet;
  endtask

  task automatic run_xfer(input stim_t s, output logic ok);
    bb_adr_t adr;
    bb_cti_e cti;
    logic    is_burst;
    logic    want_err;
    ok = 1'b1;
    adr = s.adr;
    is_burst = (s.cti == CTI_INC_BURST) || (s.cti == CTI_CONST_BURST);
    want_err = is_reserved_code(s.cti);
    for (int b = 0; b < s.beats && ok; b++) begin
      cti = (is_burst && b == s.beats - 1) ? CTI_END_OF_BURST : s.cti;
      present_beat(adr, bb_dat_t'($random(seed)), s.sel, s.we, cti, s.bte);
      take_resp(adr, s.we, s.sel, want_err, b > 0, ok);
      adr = next_beat_adr(adr, s.cti, s.bte);
    end
    if (ok) begin
      end_cycle(ok);
    end
  endtask

  // Classic reads with no idle cycle between them
  task automatic run_random_reads(input int n, output logic ok);
    bb_adr_t adr;
    ok = 1'b1;
    for (int i = 0; i < n && ok; i++) begin
      adr = bb_adr_t'(({$random(seed)} % WORDS) * 4);
      present_beat(adr, '0, 4'hf, 1'b0, CTI_CLASSIC, BTE_LINEAR);
      take_resp(adr, 1'b0, 4'hf, 1'b0, 1'b0, ok);
    end
    if (ok) begin
      end_cycle(ok);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    logic ok;
    bb_rst = 1'b1;
    bb_req = '0;
    build_table();
    repeat (4) @(posedge bb_clk);
    #DRIVE_DLY;
    bb_rst = 1'b0;
    @(negedge bb_clk);
    check_flag("bb_rsp_o.ack", 1'b0, bb_rsp.ack);
    check_flag("bb_rsp_o.err", 1'b0, bb_rsp.err);
    ok = 1'b1;
    foreach (stim_q[i]) begin
      if (ok) begin
        run_xfer(stim_q[i], ok);
      end
    end
    if (ok) begin
      run_random_reads(N_RAND, ok);
    end
    $display("Errors: data %0d, address %0d, flag %0d, timeout %0d",
             dat_errs, adr_errs, flag_errs, timeouts);
    if (dat_errs + adr_errs + flag_errs + timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+design
+incdir+bench
design/peripheral_bb_pkg.sv
design/peripheral_ram_generic_bb.sv
design/peripheral_bb_burst_ctrl.sv
design/peripheral_spram_bb.sv
bench/peripheral_spram_tb.sv

/* Makefile */
# Tool and build settings
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= peripheral_spram_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Regression passed

SOURCES := $(wildcard design/*.sv design/*.svh bench/*.sv bench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation passed, log in $(LOG)"; \
	else \
	  echo "Simulation failed, log in $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
